//--- Makefile
SIM_LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module tb_pool -f files.f

run: compile
	./obj_dir/Vtb_pool > $(SIM_LOG) 2>&1 || true
	cat $(SIM_LOG)
	@if grep -q "Testbench failed" $(SIM_LOG); then exit 1; fi
	@grep -q "Testbench passed" $(SIM_LOG)

clean:
	rm -rf obj_dir $(SIM_LOG)

//--- files.f
+incdir+.
pool_pkg.sv
pool_ctrl.sv
pool_line_buffer.sv
pool_datapath.sv
pool_top.sv
tb_pool.sv

//--- pool_ctrl.sv
// pooling job controller
`timescale 1ns/100ps
`include "pool_defines.svh"

module pool_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_n,
  input  logic                   start_i,
  input  pool_pkg::pool_cfg_t    cfg_i,
  input  logic                   in_valid_i,
  input  logic                   out_full_i,
  input  logic                   out_ready_i,
  output logic                   in_ready_o,
  output logic                   busy_o,
  output pool_pkg::pool_step_t   step_o,
  output logic                   method_o,
  output logic                   bypass_o,
  output logic [`POOL_CNT_W-1:0] col_o
);

  typedef enum logic [1:0] {
    IDLE,
    ODD_ROW,
    EVEN_ROW,
    BYPASS
  } state_t;

  state_t                 state_q;
  pool_pkg::pool_cfg_t    cfg_q;
  logic [`POOL_CNT_W-1:0] col_q;
  logic [`POOL_CNT_W-1:0] row_q;
  logic                   in_done_q;  // last input word taken, waiting for drain
  logic                   fire;
  logic                   out_free;
  logic                   last_col;
  logic                   last_row;

  assign out_free = !out_full_i || out_ready_i;  // output register can take a word
  assign last_col = (col_q == cfg_q.words_per_row - 1'b1);
  assign last_row = (row_q == cfg_q.rows - 1'b1);
  assign fire     = in_valid_i && in_ready_o;

  // the only back-pressure decision in the stage
  always_comb begin
    in_ready_o = 1'b0;
    if (!in_done_q) begin
      case (state_q)
        ODD_ROW:          in_ready_o = 1'b1;  // odd rows never produce output
        EVEN_ROW, BYPASS: in_ready_o = out_free;
        default:          in_ready_o = 1'b0;
      endcase
    end
  end

  // commands are qualified by fire in the datapath
  always_comb begin
    step_o.fire       = fire;
    step_o.store_odd  = (state_q == ODD_ROW);
    step_o.first_half = (state_q == EVEN_ROW) && !col_q[0];
    step_o.emit       = (state_q == BYPASS) || ((state_q == EVEN_ROW) && col_q[0]);
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      state_q   <= IDLE;
      cfg_q     <= '0;
      col_q     <= '0;
      row_q     <= '0;
      in_done_q <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (start_i) begin
            cfg_q     <= cfg_i;
            col_q     <= '0;
            row_q     <= '0;
            in_done_q <= 1'b0;
            state_q   <= cfg_i.pool_en ? ODD_ROW : BYPASS;  // first row is row 1
          end
        end
        default: begin
          if (in_done_q) begin
            // leave once the last output word is gone or leaves this edge
            if (out_free) begin
              state_q <= IDLE;
            end
          end else if (fire) begin
            if (last_col) begin
              col_q <= '0;
              row_q <= row_q + 1'b1;
              if (last_row) begin
                in_done_q <= 1'b1;
              end else if (state_q == ODD_ROW) begin
                state_q <= EVEN_ROW;
              end else if (state_q == EVEN_ROW) begin
                state_q <= ODD_ROW;
              end
            end else begin
              col_q <= col_q + 1'b1;
            end
          end
        end
      endcase
    end
  end

  assign busy_o   = (state_q != IDLE);
  assign method_o = cfg_q.method;
  assign bypass_o = !cfg_q.pool_en;
  assign col_o    = col_q;

  // pooling needs whole column pairs that fit in the line buffer
  a_pool_cfg: assert property (@(posedge clk_i) disable iff (!rst_n)
    (start_i && !busy_o && cfg_i.pool_en) |->
      ((cfg_i.words_per_row != '0) && !cfg_i.words_per_row[0] &&
       (cfg_i.words_per_row <= `POOL_CNT_W'(`POOL_LINE_DEPTH))));

  a_idle_quiet: assert property (@(posedge clk_i) disable iff (!rst_n)
    !busy_o |-> (step_o == '0));

endmodule

//--- pool_datapath.sv
// pooling datapath
`timescale 1ns/100ps
`include "pool_defines.svh"

module pool_datapath (
  input  logic                          clk_i,
  input  logic                          rst_n,
  input  pool_pkg::pool_word_u          in_data_i,
  input  pool_pkg::pool_step_t          step_i,
  input  logic                          method_i,
  input  logic                          bypass_i,
  input  logic signed [`POOL_SUM_W-1:0] line_i,
  input  logic                          out_ready_i,
  output logic                          line_wr_o,
  output logic signed [`POOL_SUM_W-1:0] line_data_o,
  output logic                          out_full_o,
  output pool_pkg::pool_word_u          out_data_o,
  output logic                          out_valid_o
);

  localparam int EXT_W = `POOL_SUM_W - `POOL_PIX_W;

  logic                          avg_sel;
  logic signed [`POOL_SUM_W-1:0] hi_ext;
  logic signed [`POOL_SUM_W-1:0] lo_ext;
  logic signed [`POOL_SUM_W-1:0] h_max;
  logic signed [`POOL_SUM_W-1:0] h_sum;
  logic signed [`POOL_SUM_W-1:0] h_val;
  logic signed [`POOL_SUM_W-1:0] v_max;
  logic signed [`POOL_SUM_W-1:0] v_sum;
  logic signed [`POOL_SUM_W-1:0] v_res;
  logic signed [`POOL_PIX_W-1:0] v_pix;
  logic signed [`POOL_PIX_W-1:0] lo_q;    // first pooled pixel of a column pair
  pool_pkg::pool_pix_pair_t      pair;
  pool_pkg::pool_word_u          out_q;
  logic                          out_full_q;
  logic                          load;

  assign avg_sel = (method_i == `POOL_METHOD_AVG);
  assign load    = step_i.fire && step_i.emit;

  assign hi_ext = {{EXT_W{in_data_i.pix.hi[`POOL_PIX_W-1]}}, in_data_i.pix.hi};
  assign lo_ext = {{EXT_W{in_data_i.pix.lo[`POOL_PIX_W-1]}}, in_data_i.pix.lo};

  // horizontal reduce of the incoming pair
  assign h_max = (hi_ext > lo_ext) ? hi_ext : lo_ext;
  assign h_sum = hi_ext + lo_ext;  // two pixels fit in the 18 bit sum
  assign h_val = avg_sel ? h_sum : h_max;

  // vertical combine with the stored odd row value
  assign v_max = (h_val > line_i) ? h_val : line_i;
  assign v_sum = h_val + line_i;   // four pixels still fit
  assign v_res = avg_sel ? (v_sum >>> 2) : v_max;  // arithmetic shift rounds to floor
  assign v_pix = v_res[`POOL_PIX_W-1:0];

  assign line_wr_o   = step_i.fire && step_i.store_odd;
  assign line_data_o = h_val;

  assign pair.hi = v_pix;
  assign pair.lo = lo_q;

  always_ff @(posedge clk_i) begin
    if (step_i.fire && step_i.first_half) begin
      lo_q <= v_pix;
    end
    if (load) begin
      if (bypass_i) begin
        out_q.raw <= in_data_i.raw;  // bypass word passes untouched
      end else begin
        out_q.pix <= pair;
      end
    end
  end

  // output register occupancy
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      out_full_q <= 1'b0;
    end else if (load) begin
      out_full_q <= 1'b1;
    end else if (out_ready_i) begin
      out_full_q <= 1'b0;
    end
  end

  assign out_full_o  = out_full_q;
  assign out_valid_o = out_full_q;
  assign out_data_o  = out_q;

  // the controller holds off new words while the output is stalled
  a_out_stable: assert property (@(posedge clk_i) disable iff (!rst_n)
    (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_data_o)));

endmodule

//--- pool_defines.svh
// pooling stage parameters
`ifndef POOL_DEFINES_SVH
`define POOL_DEFINES_SVH

// pixel and stream word widths
`define POOL_PIX_W        16
`define POOL_WORD_W       32

// signed two-pixel sum kept per column between rows
`define POOL_SUM_W        18

// row and column counter width, matches the config fields
`define POOL_CNT_W        16

// line buffer entries, largest word count per row
`define POOL_LINE_DEPTH   64

// method codes
`define POOL_METHOD_MAX   1'b0
`define POOL_METHOD_AVG   1'b1

`endif

//--- pool_line_buffer.sv
// pooling line buffer
`timescale 1ns/100ps
`include "pool_defines.svh"

module pool_line_buffer (
  input  logic                          clk_i,
  input  logic                          wr_en_i,
  input  logic [`POOL_CNT_W-1:0]        col_i,
  input  logic signed [`POOL_SUM_W-1:0] wr_data_i,
  output logic signed [`POOL_SUM_W-1:0] rd_data_o
);

  localparam int ADDR_W = $clog2(`POOL_LINE_DEPTH);

  // one row of horizontal results, one entry per input word
  logic signed [`POOL_SUM_W-1:0] mem_q [`POOL_LINE_DEPTH];
  logic [ADDR_W-1:0]             addr;

  assign addr = col_i[ADDR_W-1:0];

  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      mem_q[addr] <= wr_data_i;  // odd row write lands on the accepting edge
    end
  end

  // even row reads the same column in the same cycle
  assign rd_data_o = mem_q[addr];

  // the column counter comes from the controller and must stay in range
  a_col_range: assert property (@(posedge clk_i)
    wr_en_i |-> (col_i < `POOL_CNT_W'(`POOL_LINE_DEPTH)));

endmodule

//--- pool_pkg.sv
// pooling stage types
`include "pool_defines.svh"

package pool_pkg;

  // job configuration, latched on start
  typedef struct packed {
    logic [`POOL_CNT_W-1:0] words_per_row;  // input words in one row
    logic [`POOL_CNT_W-1:0] rows;           // image height
    logic                   method;         // max or average
    logic                   pool_en;        // low selects bypass
  } pool_cfg_t;

  // two pixels in one word, low pixel in the low half
  typedef struct packed {
    logic signed [`POOL_PIX_W-1:0] hi;
    logic signed [`POOL_PIX_W-1:0] lo;
  } pool_pix_pair_t;

  // stream word, raw in bypass and a pixel pair when pooling
  typedef union packed {
    logic [`POOL_WORD_W-1:0] raw;
    pool_pix_pair_t          pix;
  } pool_word_u;

  // per-beat command from the controller to the datapath
  typedef struct packed {
    logic fire;        // beat accepted this cycle
    logic store_odd;   // write horizontal result to the line buffer
    logic first_half;  // hold pooled pixel as low half
    logic emit;        // load output register
  } pool_step_t;

endpackage

//--- pool_top.sv
// pooling stage top level
`timescale 1ns/100ps
`include "pool_defines.svh"

module pool_top (
  input  logic                 clk_i,
  input  logic                 rst_n,
  input  logic                 start_i,
  input  pool_pkg::pool_cfg_t  cfg_i,
  output logic                 busy_o,
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  input  pool_pkg::pool_word_u in_data_i,
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  output pool_pkg::pool_word_u out_data_o
);

  pool_pkg::pool_step_t          step;
  logic                          method;
  logic                          bypass;
  logic [`POOL_CNT_W-1:0]        col;
  logic                          out_full;
  logic                          line_wr;
  logic signed [`POOL_SUM_W-1:0] line_wdata;
  logic signed [`POOL_SUM_W-1:0] line_rdata;

  pool_ctrl u_pool_ctrl (
    .clk_i       (clk_i),
    .rst_n       (rst_n),
    .start_i     (start_i),
    .cfg_i       (cfg_i),
    .in_valid_i  (in_valid_i),
    .out_full_i  (out_full),
    .out_ready_i (out_ready_i),
    .in_ready_o  (in_ready_o),
    .busy_o      (busy_o),
    .step_o      (step),
    .method_o    (method),
    .bypass_o    (bypass),
    .col_o       (col)
  );

  pool_line_buffer u_pool_line_buffer (
    .clk_i     (clk_i),
    .wr_en_i   (line_wr),
    .col_i     (col),
    .wr_data_i (line_wdata),
    .rd_data_o (line_rdata)
  );

  pool_datapath u_pool_datapath (
    .clk_i       (clk_i),
    .rst_n       (rst_n),
    .in_data_i   (in_data_i),
    .step_i      (step),
    .method_i    (method),
    .bypass_i    (bypass),
    .line_i      (line_rdata),
    .out_ready_i (out_ready_i),
    .line_wr_o   (line_wr),
    .line_data_o (line_wdata),
    .out_full_o  (out_full),
    .out_data_o  (out_data_o),
    .out_valid_o (out_valid_o)
  );

endmodule

//--- pool_vectors.txt
# J words_per_row rows method pool_en (decimal; method 0 max, 1 average; pool_en 0 bypass)
# I input word, O expected output word (hex, high pixel in the upper half)
J 2 2 0 0
I deadbeef
I 00000000
I ffffffff
I 12345678
O deadbeef
O 00000000
O ffffffff
O 12345678
J 4 4 0 1
I fffd0005
I fffefff8
I 00070064
I 8000ffff
I 0009fffc
I fff9fffa
I 00c8ff9c
I fff7fffb
I 00007fff
I fff6ffec
I 00030003
I ffc4ffce
I 00018000
I fff5ffe2
I 00040002
I ffd8ffba
O fffe0009
O ffff00c8
O fff67fff
O ffd80004
J 4 2 1 1
I fffeffff
I fffd000a
I 80008000
I fff90007
I fffbfffd
I fffc0002
I 80018000
I 00000001
O 0001fffd
O 00008000

//--- tb_pool.sv
// pooling stage testbench
`timescale 1ns/100ps

module tb_pool;

  logic                 clk_i = 1'b0;
  logic                 rst_n;
  logic                 start_i;
  pool_pkg::pool_cfg_t  cfg_i;
  logic                 busy_o;
  logic                 in_valid_i;
  logic                 in_ready_o;
  pool_pkg::pool_word_u in_data_i;
  logic                 out_valid_o;
  logic                 out_ready_i;
  pool_pkg::pool_word_u out_data_o;

  integer seed = 32'hc4851c53;
  int     cycles = 0;
  int     limit = 0;  // set once the vectors are loaded

  // per-job data from the vector file
  pool_pkg::pool_cfg_t  job_cfg[$];
  int                   job_nin[$];
  int                   job_nout[$];
  pool_pkg::pool_word_u in_q[$];
  pool_pkg::pool_word_u exp_q[$];

  pool_top u_pool_top (
    .clk_i       (clk_i),
    .rst_n       (rst_n),
    .start_i     (start_i),
    .cfg_i       (cfg_i),
    .busy_o      (busy_o),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .in_data_i   (in_data_i),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_data_o  (out_data_o)
  );

  always #10 clk_i = ~clk_i;  // 20 ns period

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (limit != 0 && cycles > limit) begin
      $display("timeout: the tests did not finish within %0d clock cycles", limit);
      halt_failed();
    end
  end

  task automatic halt_failed();
    $display("Testbench failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic compare_word(input string name, input pool_pkg::pool_word_u exp,
                              input pool_pkg::pool_word_u act);
    if (act !== exp) begin
      $display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp.raw, act.raw);
      halt_failed();
    end
  endtask

  task automatic compare_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[FAIL] t=%0t %s expected %b got %b", $time, name, exp, act);
      halt_failed();
    end
  endtask

  task automatic load_vectors();
    int                   fd;
    string                line;
    logic [7:0]           kind;
    int                   a;
    int                   b;
    int                   c;
    int                   d;
    logic [31:0]          w;
    pool_pkg::pool_cfg_t  cfg;
    fd = $fopen("pool_vectors.txt", "r");
    if (fd == 0) begin
      $display("could not open pool_vectors.txt");
      halt_failed();
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line[0] == "#") continue;  // blank or comment
      kind = line[0];
      if (kind == "J") begin
        void'($sscanf(line, "%c %d %d %d %d", kind, a, b, c, d));
        cfg.words_per_row = a[15:0];
        cfg.rows          = b[15:0];
        cfg.method        = c[0];
        cfg.pool_en       = d[0];
        job_cfg.push_back(cfg);
        job_nin.push_back(0);
        job_nout.push_back(0);
      end else if (kind == "I" || kind == "O") begin
        void'($sscanf(line, "%c %h", kind, w));
        if (kind == "I") begin
          in_q.push_back(w);
          job_nin[job_nin.size() - 1] += 1;
        end else begin
          exp_q.push_back(w);
          job_nout[job_nout.size() - 1] += 1;
        end
      end else begin
        $display("vector file has a line of unknown kind: %s", line);
        halt_failed();
      end
    end
    $fclose(fd);
  endtask

  // one input word per handshake, valid held until taken
  task automatic drive_inputs(input int n);
    logic took;
    for (int i = 0; i < n; i++) begin
      in_valid_i = 1'b1;
      in_data_i  = in_q.pop_front();
      took       = 1'b0;
      while (!took) begin
        @(negedge clk_i);
        took = in_ready_o;
        @(posedge clk_i);
        #2;
      end
    end
    in_valid_i = 1'b0;
  endtask

  // random back-pressure, stalled word must hold
  task automatic collect_outputs(input int n);
    int                   got;
    logic                 stalled;
    pool_pkg::pool_word_u held;
    got     = 0;
    stalled = 1'b0;
    held    = '0;
    while (got < n) begin
      out_ready_i = ($random(seed) & 3) != 0;  // ready three cycles in four
      @(negedge clk_i);
      if (stalled) begin
        compare_bit("out_valid_o", 1'b1, out_valid_o);
        compare_word("out_data_o while stalled", held, out_data_o);
      end
      stalled = out_valid_o && !out_ready_i;
      held    = out_data_o;
      if (out_valid_o && out_ready_i) begin
        compare_word("out_data_o", exp_q.pop_front(), out_data_o);
        got++;
      end
      @(posedge clk_i);
      #2;
    end
  endtask

  task automatic run_job(input pool_pkg::pool_cfg_t cfg, input int n_in, input int n_out);
    int n_exp;
    if (cfg.pool_en) begin
      n_exp = (int'(cfg.words_per_row) / 2) * (int'(cfg.rows) / 2);
    end else begin
      n_exp = int'(cfg.words_per_row) * int'(cfg.rows);
    end
    if (n_out != n_exp || n_in != int'(cfg.words_per_row) * int'(cfg.rows)) begin
      $display("vector job with %0d inputs and %0d outputs does not fit its config",
               n_in, n_out);
      halt_failed();
    end
    @(posedge clk_i);
    #2;
    start_i = 1'b1;
    cfg_i   = cfg;
    @(posedge clk_i);
    #2;
    start_i = 1'b0;
    cfg_i   = '0;  // the job must run on its latched copy
    @(negedge clk_i);
    compare_bit("busy_o", 1'b1, busy_o);
    @(posedge clk_i);
    #2;
    fork
      drive_inputs(n_in);
      collect_outputs(n_out);
    join
    @(negedge clk_i);
    while (busy_o) @(negedge clk_i);
    compare_bit("in_ready_o", 1'b0, in_ready_o);
    compare_bit("out_valid_o", 1'b0, out_valid_o);
  endtask

  initial begin
    start_i     = 1'b0;
    cfg_i       = '0;
    in_valid_i  = 1'b0;
    in_data_i   = '0;
    out_ready_i = 1'b0;
    rst_n       = 1'b0;
    load_vectors();
    limit = 4 * (in_q.size() + exp_q.size()) + 200;
    repeat (8) @(posedge clk_i);
    #2 rst_n = 1'b1;
    @(negedge clk_i);
    compare_bit("busy_o", 1'b0, busy_o);
    compare_bit("in_ready_o", 1'b0, in_ready_o);
    compare_bit("out_valid_o", 1'b0, out_valid_o);
    for (int j = 0; j < job_cfg.size(); j++) begin
      run_job(job_cfg[j], job_nin[j], job_nout[j]);
    end
    $display("Testbench passed");
    $finish;
  end

endmodule
